//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timescale 1ns/1ps
TOP       ?= tb_ex
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                    clk,
    input  logic                    arst_n,
    input  ex_types_pkg::alu_op_e   alu_op,
    input  ex_types_pkg::word_t     src_a,
    input  ex_types_pkg::word_t     src_b,
    output ex_types_pkg::word_t     alu_res,
    output logic                    overflow,
    output logic                    stall_req,
    output ex_types_pkg::word_t     hi_res,
    output ex_types_pkg::word_t     lo_res
);

    ex_types_pkg::word_t sum;
    ex_types_pkg::word_t diff;
    logic [4:0]          shamt;
    logic                is_md;
    logic                load;
    logic                step;
    logic                last;

    md_if md_bus (.clk(clk), .arst_n(arst_n));

    assign sum   = src_a + src_b;
    assign diff  = src_a - src_b;
    assign shamt = src_b[4:0];

    always_comb begin
        alu_res  = '0;
        overflow = 1'b0;
        case (alu_op)
            ex_types_pkg::ALU_ADD: begin
                alu_res  = sum;
                overflow = (src_a[31] == src_b[31]) && (sum[31] != src_a[31]);
            end
            ex_types_pkg::ALU_SUB: begin
                alu_res  = diff;
                overflow = (src_a[31] != src_b[31]) && (diff[31] != src_a[31]);
            end
            ex_types_pkg::ALU_ADDU: alu_res = sum;
            ex_types_pkg::ALU_SUBU: alu_res = diff;
            ex_types_pkg::ALU_AND:  alu_res = src_a & src_b;
            ex_types_pkg::ALU_OR:   alu_res = src_a | src_b;
            ex_types_pkg::ALU_XOR:  alu_res = src_a ^ src_b;
            ex_types_pkg::ALU_NOR:  alu_res = ~(src_a | src_b);
            ex_types_pkg::ALU_SLT:  alu_res = {31'd0, $signed(src_a) < $signed(src_b)};
            ex_types_pkg::ALU_SLTU: alu_res = {31'd0, src_a < src_b};
            ex_types_pkg::ALU_SLL:  alu_res = src_a << shamt;
            ex_types_pkg::ALU_SRL:  alu_res = src_a >> shamt;
            ex_types_pkg::ALU_SRA:  alu_res = $signed(src_a) >>> shamt;
            ex_types_pkg::ALU_LUI:  alu_res = {src_b[15:0], 16'd0};
            default:                alu_res = '0;
        endcase
    end

    always_comb begin
        is_md     = 1'b1;
        md_bus.op = ex_types_pkg::MD_MULT;
        case (alu_op)
            ex_types_pkg::ALU_MULT:  md_bus.op = ex_types_pkg::MD_MULT;
            ex_types_pkg::ALU_MULTU: md_bus.op = ex_types_pkg::MD_MULTU;
            ex_types_pkg::ALU_DIV:   md_bus.op = ex_types_pkg::MD_DIV;
            ex_types_pkg::ALU_DIVU:  md_bus.op = ex_types_pkg::MD_DIVU;
            default:                 is_md = 1'b0;
        endcase
    end

    // no restart while the finished result is still on the bus
    assign md_bus.start = is_md && !md_bus.busy && !md_bus.done;
    assign md_bus.a     = src_a;
    assign md_bus.b     = src_b;
    assign stall_req    = is_md && !md_bus.done;
    assign hi_res       = md_bus.hi;
    assign lo_res       = md_bus.lo;

    md_ctrl u_md_ctrl (
        .clk    (clk),
        .arst_n (arst_n),
        .md     (md_bus),
        .load   (load),
        .step   (step),
        .last   (last)
    );

    md_iter_counter u_md_iter_counter (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load),
        .step   (step),
        .last   (last)
    );

    md_datapath u_md_datapath (
        .clk    (clk),
        .arst_n (arst_n),
        .md     (md_bus),
        .load   (load),
        .step   (step)
    );

endmodule

//--- ex.sv
`timescale 1ns/1ps

module ex (
    input  logic                     clk,
    input  logic                     arst_n,

    input  ex_types_pkg::word_t      id2_rs_data,
    input  ex_types_pkg::word_t      id2_rt_data,
    input  ex_types_pkg::word_t      id2_ext_imme,
    input  ex_types_pkg::word_t      id2_pc,
    input  ex_types_pkg::reg_addr_t  id2_sa,
    input  ex_types_pkg::reg_addr_t  id2_w_reg_dst,

    input  ex_types_pkg::src_a_sel_e id2_src_a_sel,
    input  ex_types_pkg::src_b_sel_e id2_src_b_sel,
    input  ex_types_pkg::alu_op_e    id2_alu_op,
    input  ex_types_pkg::res_sel_e   id2_res_sel,
    input  logic                     id2_w_reg_ena,
    input  logic [1:0]               id2_w_hilo_ena,
    input  logic                     id2_w_cp0_ena,
    input  ex_types_pkg::cp0_addr_t  id2_w_cp0_addr,
    input  logic                     id2_ls_ena,
    input  logic [3:0]               id2_ls_sel,
    input  logic                     id2_check_ov,

    input  exc_pkg::exc_vec_t        id2_exc,
    input  logic                     mem_data_adel,
    input  logic                     mem_data_ades,

    input  ex_types_pkg::fwd_sel_e   forward_hi,
    input  ex_types_pkg::fwd_sel_e   forward_lo,
    input  ex_types_pkg::word_t      hilo_hi,
    input  ex_types_pkg::word_t      hilo_lo,
    input  ex_types_pkg::word_t      memc_hi_res,
    input  ex_types_pkg::word_t      memc_lo_res,
    input  ex_types_pkg::word_t      memp_hi_res,
    input  ex_types_pkg::word_t      memp_lo_res,
    input  ex_types_pkg::word_t      cp0_r_data,

    output logic                     cp0_r_ena,
    output ex_types_pkg::cp0_addr_t  cp0_r_addr,
    output logic                     ex_stall_req,
    output ex_types_pkg::word_t      ex_alu_res,
    output ex_types_pkg::word_t      ex_ls_addr,
    output ex_types_pkg::word_t      ex_hi_res,
    output ex_types_pkg::word_t      ex_lo_res,
    output logic [1:0]               ex_w_hilo_ena,
    output exc_pkg::exc_vec_t        ex_exc,
    output logic                     ex_is_overflow,
    output logic                     ex_is_data_adel,
    output logic                     ex_is_data_ades,
    output logic                     ex_has_exception,
    output ex_types_pkg::word_t      ex_pc,
    output ex_types_pkg::word_t      ex_rt_data,
    output logic                     ex_w_reg_ena,
    output ex_types_pkg::reg_addr_t  ex_w_reg_dst,
    output logic                     ex_ls_ena,
    output logic [3:0]               ex_ls_sel,
    output logic                     ex_w_cp0_ena,
    output ex_types_pkg::cp0_addr_t  ex_w_cp0_addr,
    output ex_types_pkg::word_t      ex_w_cp0_data
);

    ex_types_pkg::word_t src_a;
    ex_types_pkg::word_t src_b;
    ex_types_pkg::word_t fw_hi;
    ex_types_pkg::word_t fw_lo;
    ex_types_pkg::word_t alu_res;
    logic                alu_overflow;

    ex_operand_sel u_operand_sel (
        .src_a_sel   (id2_src_a_sel),
        .src_b_sel   (id2_src_b_sel),
        .rs_data     (id2_rs_data),
        .rt_data     (id2_rt_data),
        .ext_imme    (id2_ext_imme),
        .sa          (id2_sa),
        .forward_hi  (forward_hi),
        .forward_lo  (forward_lo),
        .hilo_hi     (hilo_hi),
        .hilo_lo     (hilo_lo),
        .memc_hi_res (memc_hi_res),
        .memc_lo_res (memc_lo_res),
        .memp_hi_res (memp_hi_res),
        .memp_lo_res (memp_lo_res),
        .src_a       (src_a),
        .src_b       (src_b),
        .fw_hi       (fw_hi),
        .fw_lo       (fw_lo)
    );

    alu u_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .alu_op    (id2_alu_op),
        .src_a     (src_a),
        .src_b     (src_b),
        .alu_res   (alu_res),
        .overflow  (alu_overflow),
        .stall_req (ex_stall_req),
        .hi_res    (ex_hi_res),
        .lo_res    (ex_lo_res)
    );

    always_comb begin
        case (id2_res_sel)
            ex_types_pkg::RES_SEL_HI:   ex_alu_res = fw_hi;
            ex_types_pkg::RES_SEL_LO:   ex_alu_res = fw_lo;
            // link address skips the delay slot
            ex_types_pkg::RES_SEL_PC_8: ex_alu_res = id2_pc + 32'd8;
            ex_types_pkg::RES_SEL_CP0:  ex_alu_res = cp0_r_data;
            default:                    ex_alu_res = alu_res;
        endcase
    end

    assign ex_ls_addr = id2_ls_ena ? (src_a + src_b) : '0;

    assign cp0_r_ena  = (id2_res_sel == ex_types_pkg::RES_SEL_CP0);
    assign cp0_r_addr = id2_w_cp0_addr;

    assign ex_exc           = id2_exc;
    assign ex_is_overflow   = id2_check_ov && alu_overflow;
    assign ex_is_data_adel  = mem_data_adel;
    assign ex_is_data_ades  = mem_data_ades;
    assign ex_has_exception = (|id2_exc) || ex_is_overflow || mem_data_adel || mem_data_ades;

    // pass down to mem
    assign ex_w_hilo_ena = id2_w_hilo_ena;
    assign ex_pc         = id2_pc;
    assign ex_rt_data    = id2_rt_data;
    assign ex_w_reg_ena  = id2_w_reg_ena;
    assign ex_w_reg_dst  = id2_w_reg_dst;
    assign ex_ls_ena     = id2_ls_ena;
    assign ex_ls_sel     = id2_ls_sel;
    assign ex_w_cp0_ena  = id2_w_cp0_ena;
    assign ex_w_cp0_addr = id2_w_cp0_addr;
    assign ex_w_cp0_data = id2_rt_data;

endmodule

//--- ex_cases.txt
# op a_sel b_sel res_sel fwd_hi fwd_lo check_ov ls_ena rs rt imme sa pc exc adel ades (hex)
# expected: result ls_addr overflow has_exception hi lo (result unused for mult/div)
0 1 1 0 0 0 1 0 7fffffff 1 0 0 0 0 0 0 80000000 0 1 1 0 0
2 1 1 0 0 0 0 0 80000000 1 0 0 0 0 0 0 7fffffff 0 0 0 0 0
1 1 1 0 0 0 1 0 7fffffff 1 0 0 0 0 0 0 80000000 0 0 0 0 0
5 1 3 0 0 0 0 0 f0f00000 0 abcd 0 0 0 0 0 f0f0abcd 0 0 0 0 0
a 2 4 0 0 0 0 0 0 3 0 4 0 0 0 0 30 0 0 0 0 0
c 2 4 0 0 0 0 0 0 80000000 0 4 0 0 0 0 f8000000 0 0 0 0 0
8 1 1 0 0 0 0 0 ffffffff 1 0 0 0 0 0 0 1 0 0 0 0 0
d 0 3 0 0 0 0 0 0 0 1234 0 0 0 0 0 12340000 0 0 0 0 0
0 1 3 0 0 0 0 1 10000000 0 fffffffc 0 0 0 0 0 0ffffffc 0ffffffc 0 0 0 0
0 0 0 3 0 0 0 0 0 0 0 0 bfc00100 10 0 0 bfc00108 0 0 1 0 0
0 0 0 4 0 0 0 0 0 0 0 0 0 0 0 1 d00df00d 0 0 1 0 0
0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 a0000001 0 0 0 0 0
0 0 0 2 0 1 0 0 0 0 0 0 0 0 0 0 b0000002 0 0 0 0 0
e 1 1 0 0 0 0 0 fffffffe 3 0 0 0 0 0 0 0 0 0 0 ffffffff fffffffa
0 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 c0000001 0 0 0 ffffffff fffffffa
f 1 1 0 0 0 0 0 ffffffff ffffffff 0 0 0 0 0 0 0 0 0 0 fffffffe 1
10 1 1 0 0 0 0 0 fffffff9 2 0 0 0 0 0 0 0 0 0 0 ffffffff fffffffd
11 1 1 0 0 0 0 0 64 7 0 0 0 0 0 0 0 0 0 0 2 e
7 1 1 0 0 0 0 0 0 0 0 0 0 0 1 0 ffffffff 0 0 1 2 e

//--- ex_operand_sel.sv
`timescale 1ns/1ps

module ex_operand_sel (
    input  ex_types_pkg::src_a_sel_e src_a_sel,
    input  ex_types_pkg::src_b_sel_e src_b_sel,
    input  ex_types_pkg::word_t      rs_data,
    input  ex_types_pkg::word_t      rt_data,
    input  ex_types_pkg::word_t      ext_imme,
    input  ex_types_pkg::reg_addr_t  sa,
    input  ex_types_pkg::fwd_sel_e   forward_hi,
    input  ex_types_pkg::fwd_sel_e   forward_lo,
    input  ex_types_pkg::word_t      hilo_hi,
    input  ex_types_pkg::word_t      hilo_lo,
    input  ex_types_pkg::word_t      memc_hi_res,
    input  ex_types_pkg::word_t      memc_lo_res,
    input  ex_types_pkg::word_t      memp_hi_res,
    input  ex_types_pkg::word_t      memp_lo_res,
    output ex_types_pkg::word_t      src_a,
    output ex_types_pkg::word_t      src_b,
    output ex_types_pkg::word_t      fw_hi,
    output ex_types_pkg::word_t      fw_lo
);

    always_comb begin
        case (src_a_sel)
            ex_types_pkg::SRC_A_SEL_RS: src_a = rs_data;
            ex_types_pkg::SRC_A_SEL_RT: src_a = rt_data;
            default:                    src_a = '0;
        endcase
    end

    always_comb begin
        case (src_b_sel)
            ex_types_pkg::SRC_B_SEL_RT:   src_b = rt_data;
            ex_types_pkg::SRC_B_SEL_RS:   src_b = rs_data;
            ex_types_pkg::SRC_B_SEL_IMME: src_b = ext_imme;
            // shift amount, zero extended
            ex_types_pkg::SRC_B_SEL_SA:   src_b = {27'd0, sa};
            default:                      src_b = '0;
        endcase
    end

    // memp is the younger of the two mem stages
    always_comb begin
        case (forward_hi)
            ex_types_pkg::FWD_MEMC: fw_hi = memc_hi_res;
            ex_types_pkg::FWD_MEMP: fw_hi = memp_hi_res;
            default:                fw_hi = hilo_hi;
        endcase
        case (forward_lo)
            ex_types_pkg::FWD_MEMC: fw_lo = memc_lo_res;
            ex_types_pkg::FWD_MEMP: fw_lo = memp_lo_res;
            default:                fw_lo = hilo_lo;
        endcase
    end

endmodule

//--- ex_types_pkg.sv
package ex_types_pkg;

    localparam int WORD_W = 32;
    localparam int MD_STEPS = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        reg_addr_t;
    // cp0 register number and select
    typedef logic [7:0]        cp0_addr_t;
    typedef logic [5:0]        md_count_t;

    typedef enum logic [5:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU
    } alu_op_e;

    typedef enum logic [2:0] {
        SRC_A_SEL_ZERO, SRC_A_SEL_RS, SRC_A_SEL_RT
    } src_a_sel_e;

    typedef enum logic [2:0] {
        SRC_B_SEL_ZERO, SRC_B_SEL_RT, SRC_B_SEL_RS, SRC_B_SEL_IMME, SRC_B_SEL_SA
    } src_b_sel_e;

    typedef enum logic [2:0] {
        RES_SEL_ALU, RES_SEL_HI, RES_SEL_LO, RES_SEL_PC_8, RES_SEL_CP0
    } res_sel_e;

    // where the current hi/lo value comes from
    typedef enum logic [1:0] {
        FWD_HILO_REG, FWD_MEMC, FWD_MEMP
    } fwd_sel_e;

    typedef enum logic [1:0] {
        MD_MULT, MD_MULTU, MD_DIV, MD_DIVU
    } md_op_e;

endpackage

//--- exc_pkg.sv
package exc_pkg;

    localparam int EXC_W = 12;

    typedef logic [EXC_W-1:0] exc_vec_t;

    // cause bit positions
    localparam int EXC_ERET        = 0;
    localparam int EXC_SYSCALL     = 1;
    localparam int EXC_BREAK       = 2;
    localparam int EXC_INST_ADEL   = 3;
    localparam int EXC_RI          = 4;
    localparam int EXC_INT         = 5;
    localparam int EXC_I_REFILL    = 6;
    localparam int EXC_I_INVALID   = 7;
    // data side tlb causes, split by load and store
    localparam int EXC_D_REFILL_L  = 8;
    localparam int EXC_D_REFILL_S  = 9;
    localparam int EXC_D_INVALID_L = 10;
    localparam int EXC_D_INVALID_S = 11;

endpackage

//--- md_ctrl.sv
`timescale 1ns/1ps

module md_ctrl (
    input  logic    clk,
    input  logic    arst_n,
    md_if.responder md,
    output logic    load,
    output logic    step,
    input  logic    last
);

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_FINISH
    } md_state_e;

    md_state_e state_q;
    md_state_e state_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= MD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            MD_IDLE: begin
                if (md.start) begin
                    state_d = MD_RUN;
                end
            end
            MD_RUN: begin
                // leave after the final step
                if (last) begin
                    state_d = MD_FINISH;
                end
            end
            default: state_d = MD_IDLE;
        endcase
    end

    assign load    = (state_q == MD_IDLE) && md.start;
    assign step    = (state_q == MD_RUN);
    assign md.busy = (state_q == MD_RUN);
    assign md.done = (state_q == MD_FINISH);

endmodule

//--- md_datapath.sv
`timescale 1ns/1ps

module md_datapath (
    input  logic    clk,
    input  logic    arst_n,
    md_if.responder md,
    input  logic    load,
    input  logic    step
);

    logic [63:0]         acc_q;
    ex_types_pkg::word_t oper_q;
    logic                is_div_q;
    logic                neg_a_q;
    logic                neg_b_q;

    logic                is_div;
    logic                is_signed;
    ex_types_pkg::word_t mag_a;
    ex_types_pkg::word_t mag_b;
    logic [32:0]         add_sum;
    logic [32:0]         sub_diff;
    logic [63:0]         prod_fix;
    ex_types_pkg::word_t rem_fix;
    ex_types_pkg::word_t quot_fix;

    assign is_div    = (md.op == ex_types_pkg::MD_DIV) || (md.op == ex_types_pkg::MD_DIVU);
    assign is_signed = (md.op == ex_types_pkg::MD_MULT) || (md.op == ex_types_pkg::MD_DIV);
    assign mag_a     = (is_signed && md.a[31]) ? -md.a : md.a;
    assign mag_b     = (is_signed && md.b[31]) ? -md.b : md.b;

    // multiply adds the multiplicand into the upper half, then shifts right
    assign add_sum  = {1'b0, acc_q[63:32]} + (acc_q[0] ? {1'b0, oper_q} : 33'd0);
    // divide trial subtract on the left shifted remainder
    assign sub_diff = acc_q[63:31] - {1'b0, oper_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q    <= '0;
            oper_q   <= '0;
            is_div_q <= 1'b0;
            neg_a_q  <= 1'b0;
            neg_b_q  <= 1'b0;
        end else if (load) begin
            acc_q    <= {32'd0, is_div ? mag_a : mag_b};
            oper_q   <= is_div ? mag_b : mag_a;
            is_div_q <= is_div;
            neg_a_q  <= is_signed && md.a[31];
            neg_b_q  <= is_signed && md.b[31];
        end else if (step) begin
            if (!is_div_q) begin
                acc_q <= {add_sum, acc_q[31:1]};
            end else if (!sub_diff[32]) begin
                acc_q <= {sub_diff[31:0], acc_q[30:0], 1'b1};
            end else begin
                acc_q <= {acc_q[62:0], 1'b0};
            end
        end
    end

    // sign fix on the held accumulator
    // remainder follows the dividend
    assign prod_fix = (neg_a_q ^ neg_b_q) ? -acc_q : acc_q;
    assign rem_fix  = neg_a_q ? -acc_q[63:32] : acc_q[63:32];
    assign quot_fix = (neg_a_q ^ neg_b_q) ? -acc_q[31:0] : acc_q[31:0];

    assign md.hi = is_div_q ? rem_fix : prod_fix[63:32];
    assign md.lo = is_div_q ? quot_fix : prod_fix[31:0];

endmodule

//--- md_if.sv
`timescale 1ns/1ps

interface md_if (
    input logic clk,
    input logic arst_n
);
    // request side
    logic                  start;
    ex_types_pkg::md_op_e  op;
    ex_types_pkg::word_t   a;
    ex_types_pkg::word_t   b;

    // response side
    logic                  busy;
    logic                  done;
    ex_types_pkg::word_t   hi;
    ex_types_pkg::word_t   lo;

    modport requester (
        input  clk, arst_n, busy, done, hi, lo,
        output start, op, a, b
    );

    modport responder (
        input  clk, arst_n, start, op, a, b,
        output busy, done, hi, lo
    );

endinterface

//--- md_iter_counter.sv
`timescale 1ns/1ps

module md_iter_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic load,
    input  logic step,
    output logic last
);

    ex_types_pkg::md_count_t count_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= ex_types_pkg::md_count_t'(ex_types_pkg::MD_STEPS);
        end else if (step) begin
            count_q <= count_q - 6'd1;
        end
    end

    // one step left
    assign last = (count_q == 6'd1);

endmodule

//--- sim.f
ex_types_pkg.sv
exc_pkg.sv
md_if.sv
ex_operand_sel.sv
md_ctrl.sv
md_iter_counter.sv
md_datapath.sv
alu.sv
ex.sv
tb_ex.sv

//--- tb_ex.sv
`timescale 1ns/1ps

module tb_ex;

    localparam int MD_STALL_CYCLES = 33;
    localparam int STALL_GUARD     = 40;

    logic                     clk;
    logic                     arst_n;
    ex_types_pkg::word_t      id2_rs_data;
    ex_types_pkg::word_t      id2_rt_data;
    ex_types_pkg::word_t      id2_ext_imme;
    ex_types_pkg::word_t      id2_pc;
    ex_types_pkg::reg_addr_t  id2_sa;
    ex_types_pkg::reg_addr_t  id2_w_reg_dst;
    ex_types_pkg::src_a_sel_e id2_src_a_sel;
    ex_types_pkg::src_b_sel_e id2_src_b_sel;
    ex_types_pkg::alu_op_e    id2_alu_op;
    ex_types_pkg::res_sel_e   id2_res_sel;
    logic                     id2_w_reg_ena;
    logic [1:0]               id2_w_hilo_ena;
    logic                     id2_w_cp0_ena;
    ex_types_pkg::cp0_addr_t  id2_w_cp0_addr;
    logic                     id2_ls_ena;
    logic [3:0]               id2_ls_sel;
    logic                     id2_check_ov;
    exc_pkg::exc_vec_t        id2_exc;
    logic                     mem_data_adel;
    logic                     mem_data_ades;
    ex_types_pkg::fwd_sel_e   forward_hi;
    ex_types_pkg::fwd_sel_e   forward_lo;
    ex_types_pkg::word_t      hilo_hi;
    ex_types_pkg::word_t      hilo_lo;
    ex_types_pkg::word_t      memc_hi_res;
    ex_types_pkg::word_t      memc_lo_res;
    ex_types_pkg::word_t      memp_hi_res;
    ex_types_pkg::word_t      memp_lo_res;
    ex_types_pkg::word_t      cp0_r_data;

    logic                     cp0_r_ena;
    ex_types_pkg::cp0_addr_t  cp0_r_addr;
    logic                     ex_stall_req;
    ex_types_pkg::word_t      ex_alu_res;
    ex_types_pkg::word_t      ex_ls_addr;
    ex_types_pkg::word_t      ex_hi_res;
    ex_types_pkg::word_t      ex_lo_res;
    logic [1:0]               ex_w_hilo_ena;
    exc_pkg::exc_vec_t        ex_exc;
    logic                     ex_is_overflow;
    logic                     ex_is_data_adel;
    logic                     ex_is_data_ades;
    logic                     ex_has_exception;
    ex_types_pkg::word_t      ex_pc;
    ex_types_pkg::word_t      ex_rt_data;
    logic                     ex_w_reg_ena;
    ex_types_pkg::reg_addr_t  ex_w_reg_dst;
    logic                     ex_ls_ena;
    logic [3:0]               ex_ls_sel;
    logic                     ex_w_cp0_ena;
    ex_types_pkg::cp0_addr_t  ex_w_cp0_addr;
    ex_types_pkg::word_t      ex_w_cp0_data;

    int     errors      = 0;
    int     checks      = 0;
    int     cycle_cnt   = 0;
    int     cycle_limit = 0;
    integer seed        = 32'h419b6bb7;
    string  case_lines[$];

    ex ex_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // add zero to zero, nothing enabled
    task automatic drive_nop();
        id2_alu_op     = ex_types_pkg::ALU_ADD;
        id2_src_a_sel  = ex_types_pkg::SRC_A_SEL_ZERO;
        id2_src_b_sel  = ex_types_pkg::SRC_B_SEL_ZERO;
        id2_res_sel    = ex_types_pkg::RES_SEL_ALU;
        forward_hi     = ex_types_pkg::FWD_HILO_REG;
        forward_lo     = ex_types_pkg::FWD_HILO_REG;
        id2_rs_data    = '0;
        id2_rt_data    = '0;
        id2_ext_imme   = '0;
        id2_pc         = '0;
        id2_sa         = '0;
        id2_w_reg_dst  = '0;
        id2_w_reg_ena  = 1'b0;
        id2_w_hilo_ena = 2'b00;
        id2_w_cp0_ena  = 1'b0;
        id2_w_cp0_addr = '0;
        id2_ls_ena     = 1'b0;
        id2_ls_sel     = 4'h0;
        id2_check_ov   = 1'b0;
        id2_exc        = '0;
        mem_data_adel  = 1'b0;
        mem_data_ades  = 1'b0;
    endtask

    task automatic insert_idle();
        int idle;
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) begin
            @(negedge clk);
            drive_nop();
        end
    endtask

    task automatic run_case(input string line);
        logic [31:0] op, a_sel, b_sel, r_sel, f_hi, f_lo, cov, lse;
        logic [31:0] rs, rt, imm, sa, pc, exc, adel, ades;
        logic [31:0] e_res, e_ls, e_ov, e_has, e_hi, e_lo;
        logic [31:0] pass_rnd;
        int          n;
        int          stall_cycles;
        logic        is_md;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    op, a_sel, b_sel, r_sel, f_hi, f_lo, cov, lse, rs, rt, imm, sa, pc,
                    exc, adel, ades, e_res, e_ls, e_ov, e_has, e_hi, e_lo);
        if (n != 22) begin
            errors++;
            $display("case line has %0d fields instead of 22: %s", n, line);
        end else begin
            @(negedge clk);
            id2_alu_op    = ex_types_pkg::alu_op_e'(op[5:0]);
            id2_src_a_sel = ex_types_pkg::src_a_sel_e'(a_sel[2:0]);
            id2_src_b_sel = ex_types_pkg::src_b_sel_e'(b_sel[2:0]);
            id2_res_sel   = ex_types_pkg::res_sel_e'(r_sel[2:0]);
            forward_hi    = ex_types_pkg::fwd_sel_e'(f_hi[1:0]);
            forward_lo    = ex_types_pkg::fwd_sel_e'(f_lo[1:0]);
            id2_check_ov  = cov[0];
            id2_ls_ena    = lse[0];
            id2_rs_data   = rs;
            id2_rt_data   = rt;
            id2_ext_imme  = imm;
            id2_sa        = sa[4:0];
            id2_pc        = pc;
            id2_exc       = exc[11:0];
            mem_data_adel = adel[0];
            mem_data_ades = ades[0];
            // pass-down fields get random values
            pass_rnd       = $random(seed);
            id2_w_reg_dst  = pass_rnd[4:0];
            id2_w_reg_ena  = pass_rnd[5];
            id2_w_hilo_ena = pass_rnd[7:6];
            id2_w_cp0_ena  = pass_rnd[8];
            id2_ls_sel     = pass_rnd[12:9];
            id2_w_cp0_addr = pass_rnd[20:13];
            is_md = (op[5:0] == ex_types_pkg::ALU_MULT) || (op[5:0] == ex_types_pkg::ALU_MULTU)
                 || (op[5:0] == ex_types_pkg::ALU_DIV) || (op[5:0] == ex_types_pkg::ALU_DIVU);
            // sample mid low phase, away from both edges
            #1;
            if (is_md) begin
                stall_cycles = 0;
                while (ex_stall_req && stall_cycles < STALL_GUARD) begin
                    stall_cycles++;
                    @(negedge clk);
                    #1;
                end
                check_value("stall cycles", stall_cycles, MD_STALL_CYCLES);
            end else begin
                check_value("stall_req", 32'(ex_stall_req), 32'd0);
                check_value("result", ex_alu_res, e_res);
            end
            check_value("ls_addr", ex_ls_addr, e_ls);
            check_value("is_overflow", 32'(ex_is_overflow), e_ov);
            check_value("has_exception", 32'(ex_has_exception), e_has);
            check_value("exc", 32'(ex_exc), exc);
            check_value("is_data_adel", 32'(ex_is_data_adel), 32'(adel[0]));
            check_value("is_data_ades", 32'(ex_is_data_ades), 32'(ades[0]));
            check_value("cp0_r_ena", 32'(cp0_r_ena),
                        32'(r_sel[2:0] == ex_types_pkg::RES_SEL_CP0));
            check_value("cp0_r_addr", 32'(cp0_r_addr), 32'(pass_rnd[20:13]));
            check_value("hi_res", ex_hi_res, e_hi);
            check_value("lo_res", ex_lo_res, e_lo);
            check_value("pc", ex_pc, pc);
            check_value("rt_data", ex_rt_data, rt);
            check_value("w_reg_dst", 32'(ex_w_reg_dst), 32'(pass_rnd[4:0]));
            check_value("w_reg_ena", 32'(ex_w_reg_ena), 32'(pass_rnd[5]));
            check_value("w_hilo_ena", 32'(ex_w_hilo_ena), 32'(pass_rnd[7:6]));
            check_value("w_cp0_ena", 32'(ex_w_cp0_ena), 32'(pass_rnd[8]));
            check_value("ls_sel", 32'(ex_ls_sel), 32'(pass_rnd[12:9]));
            check_value("w_cp0_addr", 32'(ex_w_cp0_addr), 32'(pass_rnd[20:13]));
            check_value("ls_ena", 32'(ex_ls_ena), 32'(lse[0]));
            check_value("w_cp0_data", ex_w_cp0_data, rt);
        end
    endtask

    initial begin
        int    fd;
        int    code;
        string line;
        arst_n      = 1'b0;
        hilo_hi     = 32'ha000_0001;
        hilo_lo     = 32'ha000_0002;
        memc_hi_res = 32'hb000_0001;
        memc_lo_res = 32'hb000_0002;
        memp_hi_res = 32'hc000_0001;
        memp_lo_res = 32'hc000_0002;
        cp0_r_data  = 32'hd00d_f00d;
        drive_nop();
        fd = $fopen("ex_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open ex_cases.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    case_lines.push_back(line);
                end
            end
            $fclose(fd);
            cycle_limit = case_lines.size() * 40 + 100;
            repeat (8) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;
            foreach (case_lines[i]) begin
                run_case(case_lines[i]);
                insert_idle();
            end
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule
